// File: hdl/fb_geometry_pkg.sv
/* Framebuffer geometry and address types. Row and column are truncated to these widths,
   with no check against the panel size */
`default_nettype none

package fb_geometry_pkg;

    localparam int BYTES_PER_PIXEL = 3;        // Colour bytes per pixel
    localparam int COL_FIELD_BYTES = 2;        // Column bytes on the wire

    typedef logic [3:0]  row_addr_t;           // Low part of the row byte
    typedef logic [8:0]  col_addr_t;
    typedef logic [15:0] col_field_t;          // Column as received, upper bits ignored
    typedef logic [1:0]  color_index_t;        // Byte within a pixel
    typedef logic [7:0]  pixel_byte_t;         // Pixel or command byte

    // RAM byte address, row in the top bits
    typedef struct packed {
        row_addr_t    row;
        col_addr_t    col;
        color_index_t pixel;
    } fb_addr_t;

endpackage

`default_nettype wire

// File: hdl/cmd_protocol_pkg.sv
/* Command protocol definitions. Opcodes other than the two listed are rejected
   by the decoder */
`default_nettype none

package cmd_protocol_pkg;

    typedef enum logic [7:0] {
        OP_WRITE_PIXEL = 8'h01,
        OP_READ_PIXEL  = 8'h02
    } cmd_opcode_t;

    // Which handler owns the byte stream
    typedef enum logic [1:0] {
        IDLE,
        WRITE_ACTIVE,
        READ_ACTIVE
    } handler_sel_t;

    // Framebuffer access request, one access per change of start
    typedef struct packed {
        fb_geometry_pkg::fb_addr_t    addr;
        fb_geometry_pkg::pixel_byte_t data;
        logic                         start;   // Toggle level
    } fb_req_t;

endpackage

`default_nettype wire

// File: hdl/cmd_decoder.sv
/* Opcode decoder and byte router. No back-pressure, so the host must wait for
   cmd_done before the next opcode */
`default_nettype none

module cmd_decoder (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         byte_valid,
    input  wire fb_geometry_pkg::pixel_byte_t byte_in,
    input  wire logic                         wr_done,
    input  wire logic                         rd_done,
    output logic                              wr_enable,
    output logic                              rd_enable,
    output logic                              busy,
    output logic                              cmd_done,
    output logic                              cmd_error
);

    cmd_protocol_pkg::handler_sel_t state;
    cmd_protocol_pkg::cmd_opcode_t  opcode;

    assign opcode = cmd_protocol_pkg::cmd_opcode_t'(byte_in);

    // Steer strobes to the owning handler, none once it reports done
    assign wr_enable = byte_valid && (state == cmd_protocol_pkg::WRITE_ACTIVE) && !wr_done;
    assign rd_enable = byte_valid && (state == cmd_protocol_pkg::READ_ACTIVE) && !rd_done;

    assign busy = (state != cmd_protocol_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cmd_protocol_pkg::IDLE;
            cmd_done  <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            cmd_done  <= 1'b0;                  // Both are single-cycle pulses
            cmd_error <= 1'b0;
            case (state)
                cmd_protocol_pkg::IDLE: begin
                    if (byte_valid) begin
                        case (opcode)
                            cmd_protocol_pkg::OP_WRITE_PIXEL:
                                state <= cmd_protocol_pkg::WRITE_ACTIVE;
                            cmd_protocol_pkg::OP_READ_PIXEL:
                                state <= cmd_protocol_pkg::READ_ACTIVE;
                            default:
                                cmd_error <= 1'b1;  // Stay idle
                        endcase
                    end
                end
                cmd_protocol_pkg::WRITE_ACTIVE: begin
                    if (wr_done) begin
                        state    <= cmd_protocol_pkg::IDLE;
                        cmd_done <= 1'b1;
                    end
                end
                cmd_protocol_pkg::READ_ACTIVE: begin
                    if (rd_done) begin
                        state    <= cmd_protocol_pkg::IDLE;
                        cmd_done <= 1'b1;
                    end
                end
                default: state <= cmd_protocol_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/cmd_write_pixel.sv
/* Write pixel handler. Expects row, column bytes LSB first, then BYTES_PER_PIXEL
   pixel bytes; the first pixel byte lands at the highest index */
`default_nettype none

module cmd_write_pixel (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         enable,
    input  wire fb_geometry_pkg::pixel_byte_t data_in,
    output cmd_protocol_pkg::fb_req_t         req,
    output logic                              done
);

    localparam int COL_CNT_W = $clog2(fb_geometry_pkg::COL_FIELD_BYTES);

    typedef enum logic [1:0] {
        ROW_CAPTURE,
        COLUMN_CAPTURE,
        PIXEL_STORE
    } wr_state_t;

    wr_state_t                     state;
    logic [COL_CNT_W-1:0]          col_byte_cnt;
    fb_geometry_pkg::col_field_t   col_field;
    fb_geometry_pkg::col_field_t   col_assembled;
    fb_geometry_pkg::color_index_t pix_cnt;
    fb_geometry_pkg::fb_addr_t     req_addr;
    fb_geometry_pkg::pixel_byte_t  req_data;
    logic                          req_start;
    logic                          col_last;

    // Column with the current byte merged in, little endian
    always_comb begin
        col_assembled = col_field;
        col_assembled[int'(col_byte_cnt) * 8 +: 8] = data_in;
    end

    assign col_last = (col_byte_cnt == COL_CNT_W'(fb_geometry_pkg::COL_FIELD_BYTES - 1));

    assign req = '{addr: req_addr, data: req_data, start: req_start};

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ROW_CAPTURE;
            col_byte_cnt <= '0;
            pix_cnt      <= '0;
            req_start    <= 1'b0;
            done         <= 1'b0;
        end else begin
            done <= 1'b0;
            if (enable) begin
                case (state)
                    ROW_CAPTURE: begin
                        col_byte_cnt <= '0;
                        state        <= COLUMN_CAPTURE;
                    end
                    COLUMN_CAPTURE: begin
                        if (col_last) begin
                            pix_cnt <= fb_geometry_pkg::color_index_t'(
                                fb_geometry_pkg::BYTES_PER_PIXEL - 1);
                            state   <= PIXEL_STORE;
                        end else begin
                            col_byte_cnt <= col_byte_cnt + 1'b1;
                        end
                    end
                    PIXEL_STORE: begin
                        req_start <= ~req_start;    // One RAM write per byte
                        if (pix_cnt == '0) begin
                            done  <= 1'b1;
                            state <= ROW_CAPTURE;
                        end else begin
                            pix_cnt <= pix_cnt - 1'b1;
                        end
                    end
                    default: state <= ROW_CAPTURE;
                endcase
            end
        end
    end

    // Address and data registers
    always_ff @(posedge clk) begin
        if (enable) begin
            case (state)
                ROW_CAPTURE:
                    req_addr.row <= fb_geometry_pkg::row_addr_t'(data_in);
                COLUMN_CAPTURE: begin
                    col_field    <= col_assembled;
                    req_addr.col <= fb_geometry_pkg::col_addr_t'(col_assembled);
                end
                PIXEL_STORE: begin
                    req_addr.pixel <= pix_cnt;
                    req_data       <= data_in;
                end
                default: req_data <= data_in;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/cmd_read_pixel.sv
/* Read pixel handler. After the last column byte it issues BYTES_PER_PIXEL reads on
   consecutive cycles and ignores strobes until done */
`default_nettype none

module cmd_read_pixel (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         enable,
    input  wire fb_geometry_pkg::pixel_byte_t data_in,
    output cmd_protocol_pkg::fb_req_t         req,
    output logic                              done
);

    localparam int COL_CNT_W = $clog2(fb_geometry_pkg::COL_FIELD_BYTES);

    typedef enum logic [1:0] {
        ROW_CAPTURE,
        COLUMN_CAPTURE,
        READ_ISSUE
    } rd_state_t;

    rd_state_t                     state;
    logic [COL_CNT_W-1:0]          col_byte_cnt;
    fb_geometry_pkg::col_field_t   col_field;
    fb_geometry_pkg::col_field_t   col_assembled;
    fb_geometry_pkg::color_index_t pix_cnt;
    fb_geometry_pkg::fb_addr_t     req_addr;
    logic                          req_start;
    logic                          col_last;

    always_comb begin
        col_assembled = col_field;
        col_assembled[int'(col_byte_cnt) * 8 +: 8] = data_in;
    end

    assign col_last = (col_byte_cnt == COL_CNT_W'(fb_geometry_pkg::COL_FIELD_BYTES - 1));

    assign req = '{addr: req_addr, data: '0, start: req_start};  // Reads carry no data

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ROW_CAPTURE;
            col_byte_cnt <= '0;
            pix_cnt      <= '0;
            req_start    <= 1'b0;
            done         <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ROW_CAPTURE: begin
                    if (enable) begin
                        col_byte_cnt <= '0;
                        state        <= COLUMN_CAPTURE;
                    end
                end
                COLUMN_CAPTURE: begin
                    if (enable) begin
                        if (col_last) begin
                            req_start <= ~req_start;    // First read, highest index
                            pix_cnt   <= fb_geometry_pkg::color_index_t'(
                                fb_geometry_pkg::BYTES_PER_PIXEL - 2);
                            state     <= READ_ISSUE;
                        end else begin
                            col_byte_cnt <= col_byte_cnt + 1'b1;
                        end
                    end
                end
                READ_ISSUE: begin
                    req_start <= ~req_start;            // Free-running, one per cycle
                    if (pix_cnt == '0) begin
                        done  <= 1'b1;                  // With the final request
                        state <= ROW_CAPTURE;
                    end else begin
                        pix_cnt <= pix_cnt - 1'b1;
                    end
                end
                default: state <= ROW_CAPTURE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ROW_CAPTURE:
                if (enable) req_addr.row <= fb_geometry_pkg::row_addr_t'(data_in);
            COLUMN_CAPTURE: begin
                if (enable) begin
                    col_field      <= col_assembled;
                    req_addr.col   <= fb_geometry_pkg::col_addr_t'(col_assembled);
                    req_addr.pixel <= fb_geometry_pkg::color_index_t'(
                        fb_geometry_pkg::BYTES_PER_PIXEL - 1);
                end
            end
            READ_ISSUE:
                req_addr.pixel <= pix_cnt;
            default: req_addr.pixel <= pix_cnt;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/fb_ram.sv
/* Byte framebuffer, one access per start toggle on each port. Read data appears
   READ_LATENCY cycles after the read edge, in request order */
`default_nettype none

module fb_ram #(
    parameter int READ_LATENCY = 2              // 1 or 2
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire cmd_protocol_pkg::fb_req_t    wr_req,
    input  wire cmd_protocol_pkg::fb_req_t    rd_req,
    output logic                              pixel_valid,
    output fb_geometry_pkg::pixel_byte_t      pixel_out
);

    localparam int DEPTH = 1 << $bits(fb_geometry_pkg::fb_addr_t);

    fb_geometry_pkg::pixel_byte_t mem [0:DEPTH-1];
    fb_geometry_pkg::pixel_byte_t data_pipe [0:READ_LATENCY];
    logic [READ_LATENCY:0]        valid_pipe;   // Stage 0 is the array read
    logic                         wr_seen;
    logic                         rd_seen;
    logic                         wr_new;
    logic                         rd_new;

    assign wr_new = (wr_req.start != wr_seen);
    assign rd_new = (rd_req.start != rd_seen);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_seen    <= 1'b0;
            rd_seen    <= 1'b0;
            valid_pipe <= '0;
        end else begin
            wr_seen    <= wr_req.start;
            rd_seen    <= rd_req.start;
            valid_pipe <= {valid_pipe[READ_LATENCY-1:0], rd_new};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_new && !reset) begin
            mem[wr_req.addr] <= wr_req.data;
        end
        data_pipe[0] <= mem[rd_req.addr];        // Qualified by valid_pipe[0]
        for (int k = 1; k <= READ_LATENCY; k++) begin
            data_pipe[k] <= data_pipe[k-1];
        end
    end

    // Several reads may be in flight
    assign pixel_valid = valid_pipe[READ_LATENCY];
    assign pixel_out   = data_pipe[READ_LATENCY];

endmodule

`default_nettype wire

// File: hdl/display_ctrl_top.sv
/* Framebuffer command controller top. One command at a time; send the next opcode
   only after cmd_done */
`default_nettype none

module display_ctrl_top #(
    parameter int READ_LATENCY = 2
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         byte_valid,
    input  wire fb_geometry_pkg::pixel_byte_t byte_in,
    output logic                              pixel_valid,
    output fb_geometry_pkg::pixel_byte_t      pixel_out,
    output logic                              busy,
    output logic                              cmd_done,
    output logic                              cmd_error
);

    logic                      wr_enable;
    logic                      rd_enable;
    logic                      wr_done;
    logic                      rd_done;
    cmd_protocol_pkg::fb_req_t wr_req;
    cmd_protocol_pkg::fb_req_t rd_req;

    cmd_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_in    (byte_in),
        .wr_done    (wr_done),
        .rd_done    (rd_done),
        .wr_enable  (wr_enable),
        .rd_enable  (rd_enable),
        .busy       (busy),
        .cmd_done   (cmd_done),
        .cmd_error  (cmd_error)
    );

    cmd_write_pixel u_write (
        .clk     (clk),
        .reset   (reset),
        .enable  (wr_enable),
        .data_in (byte_in),
        .req     (wr_req),
        .done    (wr_done)
    );

    cmd_read_pixel u_read (
        .clk     (clk),
        .reset   (reset),
        .enable  (rd_enable),
        .data_in (byte_in),
        .req     (rd_req),
        .done    (rd_done)
    );

    fb_ram #(
        .READ_LATENCY (READ_LATENCY)
    ) u_ram (
        .clk         (clk),
        .reset       (reset),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .pixel_valid (pixel_valid),
        .pixel_out   (pixel_out)
    );

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
/* Free-running testbench clock, period 4, starting low */
`default_nettype none

module clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 2;

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: bench/display_ctrl_assertions.sv
/* Concurrent checks bound into display_ctrl_top. Reads the decoder enables and
   request start bits from the top-level wires */
`default_nettype none

module display_ctrl_assertions (
    input wire logic clk,
    input wire logic reset,
    input wire logic wr_enable,
    input wire logic rd_enable,
    input wire logic wr_start,
    input wire logic rd_start,
    input wire logic busy,
    input wire logic cmd_done,
    input wire logic cmd_error,
    input wire logic pixel_valid
);

    int failures = 0;

    assert property (@(posedge clk) disable iff (reset) !(wr_enable && rd_enable))
        else begin
            $error("Both handler enables high");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset) !(cmd_done && cmd_error))
        else begin
            $error("cmd_done and cmd_error together");
            failures++;
        end

    // Only one handler may toggle its RAM request per cycle
    assert property (@(posedge clk) disable iff (reset)
        !((wr_start != $past(wr_start)) && (rd_start != $past(rd_start))))
        else begin
            $error("Both request start bits changed");
            failures++;
        end

    assert property (@(posedge clk) $fell(reset) |-> !busy && !cmd_done && !pixel_valid)
        else begin
            $error("Outputs not idle after reset");
            failures++;
        end

endmodule

bind display_ctrl_top display_ctrl_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .wr_enable   (wr_enable),              // Decoder enables
    .rd_enable   (rd_enable),
    .wr_start    (wr_req.start),
    .rd_start    (rd_req.start),
    .busy        (busy),
    .cmd_done    (cmd_done),
    .cmd_error   (cmd_error),
    .pixel_valid (pixel_valid)
);

`default_nettype wire

// File: bench/tb_display_ctrl.sv
/* Testbench for display_ctrl_top, READ_LATENCY 2. Only pixels written earlier are
   read back, since the framebuffer has no initial contents */
`default_nettype none

module tb_display_ctrl;

    localparam int READ_LATENCY    = 2;
    localparam int BPP             = fb_geometry_pkg::BYTES_PER_PIXEL;
    localparam int COL_BYTES       = fb_geometry_pkg::COL_FIELD_BYTES;
    localparam int WRITE_LEN       = 1 + COL_BYTES + BPP;   // Bytes after the opcode
    localparam int READ_LEN        = 1 + COL_BYTES;
    localparam int N_RAND          = 12;
    localparam int NUM_CMDS        = 7 + 3 * N_RAND;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * 20 + 200;
    localparam fb_geometry_pkg::pixel_byte_t OP_WR =
        fb_geometry_pkg::pixel_byte_t'(cmd_protocol_pkg::OP_WRITE_PIXEL);
    localparam fb_geometry_pkg::pixel_byte_t OP_RD =
        fb_geometry_pkg::pixel_byte_t'(cmd_protocol_pkg::OP_READ_PIXEL);

    logic                         clk;
    logic                         reset;
    logic                         byte_valid;
    fb_geometry_pkg::pixel_byte_t byte_in;
    logic                         pixel_valid;
    fb_geometry_pkg::pixel_byte_t pixel_out;
    logic                         busy;
    logic                         cmd_done;
    logic                         cmd_error;

    int                           seed = 32'hcca2e4bf;
    int                           errors = 0;
    fb_geometry_pkg::pixel_byte_t shadow [int];        // Written bytes by RAM index
    fb_geometry_pkg::pixel_byte_t exp_q [$];           // Read bytes in request order
    fb_geometry_pkg::pixel_byte_t rows [N_RAND];
    fb_geometry_pkg::col_field_t  cols [N_RAND];

    logic m_busy = 1'b0;                               // Command model state
    logic m_write = 1'b0;
    logic err_next = 1'b0;
    int   m_bytes = 0;
    int   done_wait = 0;

    clock_gen u_clock (.clk(clk));

    display_ctrl_top #(
        .READ_LATENCY (READ_LATENCY)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_in     (byte_in),
        .pixel_valid (pixel_valid),
        .pixel_out   (pixel_out),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .cmd_error   (cmd_error)
    );

    // Row and column truncated to the RAM widths, colour index in the low bits
    function automatic int fb_index(input fb_geometry_pkg::pixel_byte_t row,
                                    input fb_geometry_pkg::col_field_t col, input int idx);
        int row_span;
        int col_span;
        int idx_span;
        row_span = 1 << $bits(fb_geometry_pkg::row_addr_t);
        col_span = 1 << $bits(fb_geometry_pkg::col_addr_t);
        idx_span = 1 << $bits(fb_geometry_pkg::color_index_t);
        return ((int'(row) % row_span) * col_span + int'(col) % col_span) * idx_span + idx;
    endfunction

    function automatic fb_geometry_pkg::pixel_byte_t fb_expected_byte(
        input fb_geometry_pkg::pixel_byte_t row, input fb_geometry_pkg::col_field_t col,
        input int idx);
        int a;
        a = fb_index(row, col, idx);
        if (!shadow.exists(a)) begin
            errors++;
            $display("Read of RAM byte %0d, which was never written", a);
            return '0;
        end
        return shadow[a];
    endfunction

    task automatic check_pixel_byte(input string name, input fb_geometry_pkg::pixel_byte_t exp,
                                    input fb_geometry_pkg::pixel_byte_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_byte(input fb_geometry_pkg::pixel_byte_t b);
        byte_valid = 1'b1;
        byte_in    = b;
        @(posedge clk);
        #1;
        byte_valid = 1'b0;
    endtask

    task automatic send_column(input fb_geometry_pkg::col_field_t col);
        for (int k = 0; k < COL_BYTES; k++) begin
            send_byte(fb_geometry_pkg::pixel_byte_t'(col >> (8 * k)));   // LSB first
        end
    endtask

    // Bounded by the watchdog
    task automatic wait_cmd_done();
        do begin
            @(posedge clk);
            #1;
        end while (!cmd_done);
    endtask

    task automatic write_pixel(input fb_geometry_pkg::pixel_byte_t row,
                               input fb_geometry_pkg::col_field_t col);
        fb_geometry_pkg::pixel_byte_t b;
        send_byte(OP_WR);
        send_byte(row);
        send_column(col);
        for (int k = BPP - 1; k >= 0; k--) begin            // First byte at highest index
            b = fb_geometry_pkg::pixel_byte_t'($random(seed));
            shadow[fb_index(row, col, k)] = b;
            send_byte(b);
        end
        wait_cmd_done();
    endtask

    task automatic read_pixel(input fb_geometry_pkg::pixel_byte_t row,
                              input fb_geometry_pkg::col_field_t col);
        for (int k = BPP - 1; k >= 0; k--) begin
            exp_q.push_back(fb_expected_byte(row, col, k));
        end
        send_byte(OP_RD);
        send_byte(row);
        send_column(col);
        wait_cmd_done();
    endtask

    // Model of the command timing plus the read data compare
    always @(negedge clk) begin
        logic exp_done;
        logic exp_err;
        if (!reset) begin
            exp_done = (done_wait == 1);
            exp_err  = err_next;
            if (exp_done) m_busy = 1'b0;
            check_flag("cmd_done", exp_done, cmd_done);
            check_flag("cmd_error", exp_err, cmd_error);
            check_flag("busy", m_busy, busy);
            if (done_wait > 0) done_wait--;
            err_next = 1'b0;
            if (byte_valid && !m_busy) begin
                if (byte_in == OP_WR || byte_in == OP_RD) begin
                    m_busy  = 1'b1;
                    m_write = (byte_in == OP_WR);
                    m_bytes = 0;
                end else begin
                    err_next = 1'b1;                        // Error pulse next cycle
                end
            end else if (byte_valid && done_wait == 0) begin
                m_bytes++;
                if (m_bytes == (m_write ? WRITE_LEN : READ_LEN))
                    done_wait = m_write ? 2 : 4;            // Handler done plus one
            end
            if (pixel_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("pixel_valid seen with no read byte outstanding at %0t", $time);
                end else begin
                    check_pixel_byte("pixel_out", exp_q.pop_front(), pixel_out);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_in    = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        write_pixel(8'hF3, 16'h01A5);                       // Single pixel round trip
        read_pixel(8'hF3, 16'h01A5);
        read_pixel(8'h03, 16'hFFA5);                        // Same pixel via truncation

        rows[0] = 8'hFE;
        cols[0] = 16'h8123;
        for (int i = 1; i < N_RAND; i++) begin
            rows[i] = fb_geometry_pkg::pixel_byte_t'($random(seed));
            cols[i] = fb_geometry_pkg::col_field_t'($random(seed));
        end
        for (int i = 0; i < N_RAND; i++) write_pixel(rows[i], cols[i]);
        for (int i = 0; i < N_RAND; i++) read_pixel(rows[i], cols[i]);

        for (int i = N_RAND - 1; i >= 0; i--) read_pixel(rows[i], cols[i]);

        send_byte(8'h00);                                   // Invalid opcodes
        idle(2);
        send_byte(8'hA5);
        idle(2);
        write_pixel(8'h15, 16'h0200);
        read_pixel(8'h15, 16'h0200);

        idle(READ_LATENCY + 6);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected pixel bytes never arrived", exp_q.size());
        end
        $display("Errors: %0d (compare %0d, assertions %0d)",
                 errors + UUT.u_assertions.failures, errors, UUT.u_assertions.failures);
        if (errors + UUT.u_assertions.failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/fb_geometry_pkg.sv
hdl/cmd_protocol_pkg.sv
hdl/cmd_decoder.sv
hdl/cmd_write_pixel.sv
hdl/cmd_read_pixel.sv
hdl/fb_ram.sv
hdl/display_ctrl_top.sv
bench/clock_gen.sv
bench/display_ctrl_assertions.sv
bench/tb_display_ctrl.sv

// File: Makefile
# Verilator build and run for the display controller testbench

SIM        = verilator
TOP        = tb_display_ctrl
FILELIST   = compile.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --assert --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
RUN_ARGS   = +verilator+error+limit+1000
PASS_MSG   = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
